/* logic/timer_config.svh */
`ifndef TIMER_CONFIG_SVH
`define TIMER_CONFIG_SVH

// Register map, byte offsets on the AXI4-Lite bus.
`define TIMER_ADDR_W      4
`define TIMER_VALUE_OFS   4'h0
`define TIMER_CTRL_OFS    4'h4
`define TIMER_MAX_OFS     4'h8
`define TIMER_STATUS_OFS  4'hC

// Bus data word.
`define TIMER_DATA_W      32

// Timer field widths.
`define TIMER_VALUE_W     16
`define TIMER_PRESCALE_W  4

// Max register comes up at full range.
`define TIMER_MAX_RESET   16'hFFFF

`endif

/* logic/timerPkg.sv */
`default_nettype none
`include "timer_config.svh"

package timerPkg;

	// Counter and maximum values.
	typedef logic [`TIMER_VALUE_W-1:0] timerValueT;
	// Divisor minus one.
	typedef logic [`TIMER_PRESCALE_W-1:0] prescaleT;

	// Bus vectors.
	typedef logic [`TIMER_ADDR_W-1:0] axiAddrT;
	typedef logic [`TIMER_DATA_W-1:0] axiDataT;
	typedef logic [1:0] axiRespT;

	// Response codes.
	localparam axiRespT respOkay = 2'b00;
	localparam axiRespT respSlvErr = 2'b10;

	// Master side of the AXI4-Lite link.
	typedef struct packed {
		axiAddrT awaddr;
		logic    awvalid;
		axiDataT wdata;
		logic    wvalid;
		logic    bready;
		axiAddrT araddr;
		logic    arvalid;
		logic    rready;
	} axiLiteReqT;

	// Slave side of the AXI4-Lite link.
	typedef struct packed {
		logic    awready;
		logic    wready;
		axiRespT bresp;
		logic    bvalid;
		logic    arready;
		axiDataT rdata;
		axiRespT rresp;
		logic    rvalid;
	} axiLiteRspT;

	// Settings handed from the register block to the core.
	typedef struct packed {
		logic       enable;
		prescaleT   prescale;
		timerValueT max;
	} timerCtrlT;

endpackage

`default_nettype wire

/* logic/timerRegs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "timer_config.svh"

module timerRegs (
	input  logic                 clk,
	input  logic                 arstN,
	input  timerPkg::axiLiteReqT axiReq,
	output timerPkg::axiLiteRspT axiRsp,
	output timerPkg::timerCtrlT  ctrl,
	output logic                 valueLoad,
	output timerPkg::timerValueT loadValue,
	input  timerPkg::timerValueT counterValue,
	input  logic                 wrap
);

	// Handshake state.
	logic wrAccept;
	logic rdAccept;
	logic bvalid;
	logic rvalid;
	timerPkg::axiRespT bresp;
	timerPkg::axiRespT rresp;
	timerPkg::axiDataT rdata;

	// Write decode.
	logic selValue;
	logic selCtrl;
	logic selMax;
	logic selStatus;
	logic wrAddrOk;

	// Read decode.
	timerPkg::axiDataT rdNext;
	logic rdAddrOk;

	// Sticky wrap flag.
	logic statusFlag;

	// Address and data are taken together, only with no response pending.
	assign wrAccept = axiReq.awvalid & axiReq.wvalid & ~bvalid;
	// One read in flight at a time.
	assign rdAccept = axiReq.arvalid & ~rvalid;

	// Only the four aligned offsets are real registers.
	always_comb begin
		selValue = 1'b0;
		selCtrl = 1'b0;
		selMax = 1'b0;
		selStatus = 1'b0;
		wrAddrOk = 1'b1;
		case (axiReq.awaddr)
			`TIMER_VALUE_OFS:  selValue = 1'b1;
			`TIMER_CTRL_OFS:   selCtrl = 1'b1;
			`TIMER_MAX_OFS:    selMax = 1'b1;
			`TIMER_STATUS_OFS: selStatus = 1'b1;
			default:           wrAddrOk = 1'b0;
		endcase
	end

	// Value writes go straight to the core as a load strobe.
	assign valueLoad = wrAccept & selValue;
	assign loadValue = axiReq.wdata[`TIMER_VALUE_W-1:0];

	// Control and max fields.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrl.enable <= 1'b0;
			ctrl.prescale <= '0;
			ctrl.max <= `TIMER_MAX_RESET;
		end else if (wrAccept) begin
			if (selCtrl) begin
				ctrl.enable <= axiReq.wdata[0];
				ctrl.prescale <= axiReq.wdata[`TIMER_PRESCALE_W+3:4];
			end
			if (selMax) begin
				ctrl.max <= axiReq.wdata[`TIMER_VALUE_W-1:0];
			end
		end
	end

	// Wrap sets the flag and beats a same-cycle clear.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			statusFlag <= 1'b0;
		end else if (wrap) begin
			statusFlag <= 1'b1;
		end else if (wrAccept && selStatus && axiReq.wdata[0]) begin
			statusFlag <= 1'b0;
		end
	end

	// Write response, held until bready.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			bvalid <= 1'b0;
		end else if (wrAccept) begin
			bvalid <= 1'b1;
		end else if (axiReq.bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept) begin
			bresp <= wrAddrOk ? timerPkg::respOkay : timerPkg::respSlvErr;
		end
	end

	// Readback mux, unused bits stay zero.
	always_comb begin
		rdNext = '0;
		rdAddrOk = 1'b1;
		case (axiReq.araddr)
			`TIMER_VALUE_OFS: rdNext[`TIMER_VALUE_W-1:0] = counterValue;
			`TIMER_CTRL_OFS: begin
				rdNext[0] = ctrl.enable;
				rdNext[`TIMER_PRESCALE_W+3:4] = ctrl.prescale;
			end
			`TIMER_MAX_OFS:    rdNext[`TIMER_VALUE_W-1:0] = ctrl.max;
			`TIMER_STATUS_OFS: rdNext[0] = statusFlag;
			default:           rdAddrOk = 1'b0;
		endcase
	end

	// Read response, held until rready.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rvalid <= 1'b0;
		end else if (rdAccept) begin
			rvalid <= 1'b1;
		end else if (axiReq.rready) begin
			rvalid <= 1'b0;
		end
	end

	// Data sampled at acceptance.
	always_ff @(posedge clk) begin
		if (rdAccept) begin
			rdata <= rdNext;
			rresp <= rdAddrOk ? timerPkg::respOkay : timerPkg::respSlvErr;
		end
	end

	// Drive the slave side of the bus.
	always_comb begin
		axiRsp.awready = wrAccept;
		axiRsp.wready = wrAccept;
		axiRsp.bresp = bresp;
		axiRsp.bvalid = bvalid;
		axiRsp.arready = rdAccept;
		axiRsp.rdata = rdata;
		axiRsp.rresp = rresp;
		axiRsp.rvalid = rvalid;
	end

endmodule

`default_nettype wire

/* logic/timerCore.sv */
`timescale 1ns/100ps
`default_nettype none

module timerCore (
	input  logic                 clk,
	input  logic                 arstN,
	input  timerPkg::timerCtrlT  ctrl,
	input  logic                 valueLoad,
	input  timerPkg::timerValueT loadValue,
	output timerPkg::timerValueT value,
	output logic                 wrap,
	output logic                 irq
);

	// Prescaler count.
	timerPkg::prescaleT psCount;
	// Counter advance strobe.
	logic tick;
	// Counter sits at the wrap point.
	logic atMax;

	// Tick ends each prescale period.
	// Greater-or-equal also recovers when prescale is lowered mid-count.
	assign tick = ctrl.enable & (psCount >= ctrl.prescale);
	assign atMax = (value == ctrl.max);

	// Wrap from max to zero, unless a load takes the edge.
	assign wrap = tick & atMax & ~valueLoad;

	// Prescaler restarts on load, on tick and while disabled.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			psCount <= '0;
		end else if (valueLoad || !ctrl.enable || tick) begin
			psCount <= '0;
		end else begin
			psCount <= psCount + 1'b1;
		end
	end

	// Value counter.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			value <= '0;
		end else if (valueLoad) begin
			// Bus load wins over counting.
			value <= loadValue;
		end else if (tick) begin
			if (atMax) begin
				value <= '0;
			end else begin
				value <= value + 1'b1;
			end
		end
	end

	// Interrupt lags wrap by one cycle.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			irq <= 1'b0;
		end else begin
			irq <= wrap;
		end
	end

endmodule

`default_nettype wire

/* logic/timerTop.sv */
`timescale 1ns/100ps
`default_nettype none

module timerTop (
	input  logic                 clk,
	input  logic                 arstN,
	input  timerPkg::axiLiteReqT axiReq,
	output timerPkg::axiLiteRspT axiRsp,
	output logic                 irq
);

	// Register block to core.
	timerPkg::timerCtrlT ctrl;
	logic valueLoad;
	timerPkg::timerValueT loadValue;
	// Core back to register block.
	timerPkg::timerValueT counterValue;
	logic wrap;

	// Bus slave and register file.
	timerRegs timerRegs_i (
		.clk          (clk),
		.arstN        (arstN),
		.axiReq       (axiReq),
		.axiRsp       (axiRsp),
		.ctrl         (ctrl),
		.valueLoad    (valueLoad),
		.loadValue    (loadValue),
		.counterValue (counterValue),
		.wrap         (wrap)
	);

	// Prescaler and counter.
	timerCore timerCore_i (
		.clk       (clk),
		.arstN     (arstN),
		.ctrl      (ctrl),
		.valueLoad (valueLoad),
		.loadValue (loadValue),
		.value     (counterValue),
		.wrap      (wrap),
		.irq       (irq)
	);

endmodule

`default_nettype wire

/* dv/timerTb_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module timerAssert (
	input logic                 clk,
	input logic                 arstN,
	input timerPkg::axiLiteReqT axiReq,
	input timerPkg::axiLiteRspT axiRsp,
	input logic                 irq
);

	// Set once any assertion below has failed.
	logic failSeen;

	initial failSeen = 1'b0;

	// Write response stays up until the master takes it.
	bvalidHold: assert property (@(posedge clk) disable iff (!arstN)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
		else begin
			failSeen = 1'b1;
			$error("bvalid dropped before bready");
		end

	// Same for read data.
	rvalidHold: assert property (@(posedge clk) disable iff (!arstN)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
		else begin
			failSeen = 1'b1;
			$error("rvalid dropped before rready");
		end

	// Interrupt is a single-cycle pulse.
	irqPulse: assert property (@(posedge clk) disable iff (!arstN)
		irq |=> !irq)
		else begin
			failSeen = 1'b1;
			$error("irq high for two cycles");
		end

	// Address and data only taken together, both readies in step.
	awreadyValid: assert property (@(posedge clk) disable iff (!arstN)
		axiRsp.awready || axiRsp.wready |-> axiRsp.awready && axiRsp.wready &&
			axiReq.awvalid && axiReq.wvalid)
		else begin
			failSeen = 1'b1;
			$error("awready or wready out of step with awvalid and wvalid");
		end

endmodule

bind timerTop timerAssert timerAssert_i (
	.clk    (clk),
	.arstN  (arstN),
	.axiReq (axiReq),
	.axiRsp (axiRsp),
	.irq    (irq)
);

`default_nettype wire

/* dv/timerTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "timer_config.svh"

module timerTb;

	// One line of the stimulus file.
	typedef struct packed {
		logic [7:0]        op;
		timerPkg::axiAddrT addr;
		timerPkg::axiDataT data;
		timerPkg::axiDataT expVal;
		timerPkg::axiRespT resp;
	} stepT;

	logic clk;
	logic arstN;
	timerPkg::axiLiteReqT axiReq;
	timerPkg::axiLiteRspT axiRsp;
	logic irq;
	int cycles = 0;
	// Zero until the file is loaded.
	int limit = 0;
	stepT steps[$];

	timerTop timerTop_i (
		.clk    (clk),
		.arstN  (arstN),
		.axiReq (axiReq),
		.axiRsp (axiRsp),
		.irq    (irq)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic stopRun(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// Cycle count, also the time base for irq periods.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			stopRun($sformatf("Run did not finish within %0d cycles", limit));
		end
		if (timerTop_i.timerAssert_i.failSeen) begin
			stopRun("A bound assertion on the bus or irq failed");
		end
	end

	task automatic checkData(input string name, input timerPkg::axiDataT got,
			input timerPkg::axiDataT exp);
		if (got !== exp) begin
			stopRun($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkResp(input string name, input timerPkg::axiRespT got,
			input timerPkg::axiRespT exp);
		if (got !== exp) begin
			stopRun($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkPeriod(input string name, input int got, input int exp);
		if (got != exp) begin
			stopRun($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// Random hold-off before accepting a response.
	task automatic stallCycles();
		int n;
		n = $urandom_range(3);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic axiWrite(input timerPkg::axiAddrT addr, input timerPkg::axiDataT data,
			output timerPkg::axiRespT resp);
		@(posedge clk);
		#1;
		axiReq.awaddr = addr;
		axiReq.wdata = data;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid = 1'b1;
		@(negedge clk);
		while (!(axiRsp.awready && axiRsp.wready)) @(negedge clk);
		@(posedge clk);
		#1;
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		stallCycles();
		axiReq.bready = 1'b1;
		@(negedge clk);
		while (!axiRsp.bvalid) @(negedge clk);
		resp = axiRsp.bresp;
		@(posedge clk);
		#1;
		axiReq.bready = 1'b0;
	endtask

	task automatic axiRead(input timerPkg::axiAddrT addr, output timerPkg::axiDataT data,
			output timerPkg::axiRespT resp);
		@(posedge clk);
		#1;
		axiReq.araddr = addr;
		axiReq.arvalid = 1'b1;
		@(negedge clk);
		while (!axiRsp.arready) @(negedge clk);
		@(posedge clk);
		#1;
		axiReq.arvalid = 1'b0;
		stallCycles();
		axiReq.rready = 1'b1;
		@(negedge clk);
		while (!axiRsp.rvalid) @(negedge clk);
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		@(posedge clk);
		#1;
		axiReq.rready = 1'b0;
	endtask

	// Cycles between two successive irq pulses.
	task automatic measurePeriod(output int period);
		int start;
		@(negedge clk);
		while (!irq) @(negedge clk);
		start = cycles;
		@(negedge clk);
		while (!irq) @(negedge clk);
		period = cycles - start;
	endtask

	task automatic loadFile();
		int fd;
		int n;
		int periods;
		string line;
		stepT s;
		logic [7:0] op;
		int a;
		int d;
		int e;
		int r;
		periods = 0;
		fd = $fopen("dv/timer_testdata.txt", "r");
		if (fd == 0) begin
			stopRun("Could not open the stimulus file dv/timer_testdata.txt");
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line[0] == "#") continue;
			n = $sscanf(line, "%c %h %h %h %h", op, a, d, e, r);
			if (n != 5) begin
				stopRun($sformatf("Malformed stimulus line: %s", line));
			end
			s.op = op;
			s.addr = a[`TIMER_ADDR_W-1:0];
			s.data = d;
			s.expVal = e;
			s.resp = r[1:0];
			steps.push_back(s);
			if (op == "P") periods += e;
		end
		$fclose(fd);
		limit = 200 * steps.size() + periods;
	endtask

	task automatic playSteps();
		stepT s;
		timerPkg::axiDataT data;
		timerPkg::axiDataT val;
		timerPkg::axiRespT resp;
		int period;
		foreach (steps[i]) begin
			s = steps[i];
			case (s.op)
				"W": begin
					axiWrite(s.addr, s.data, resp);
					checkResp("bresp", resp, s.resp);
				end
				"R": begin
					axiRead(s.addr, data, resp);
					checkData("rdata", data, s.expVal);
					checkResp("rresp", resp, s.resp);
				end
				"L": begin
					// Random value, only the low 16 bits exist.
					val = $urandom_range(16'hFFFF);
					axiWrite(`TIMER_VALUE_OFS, val, resp);
					checkResp("bresp", resp, timerPkg::respOkay);
					axiRead(`TIMER_VALUE_OFS, data, resp);
					checkData("rdata", data, val);
					checkResp("rresp", resp, timerPkg::respOkay);
				end
				"P": begin
					measurePeriod(period);
					checkPeriod("irq period", period, int'(s.expVal));
				end
				default: stopRun($sformatf("Unknown operation %c in the stimulus file", s.op));
			endcase
		end
	endtask

	initial begin
		axiReq = '0;
		arstN = 1'b0;
		void'($urandom(41113));
		loadFile();
		repeat (2) @(posedge clk);
		#1;
		arstN = 1'b1;
		playSteps();
		if (timerTop_i.timerAssert_i.failSeen) begin
			stopRun("A bound assertion on the bus or irq failed");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dv/timer_testdata.txt */
# op addr data expect resp, all hex; expect is read data or irq period
# W write, R read, L random VALUE load with readback, P irq period
R 0 0 0 0
R 4 0 0 0
R 8 0 ffff 0
R c 0 0 0
W 4 fff0 0 0
R 4 0 f0 0
W 8 9 0 0
R 8 0 9 0
L 0 0 0 0
W f 5 0 2
R f 0 0 2
W 6 5 0 2
R 6 0 0 2
R 8 0 9 0
R 4 0 f0 0
W 0 0 0 0
W 4 31 0 0
P 0 0 28 0
W 0 0 0 0
W 8 4 0 0
W 4 1 0 0
P 0 0 5 0
W 4 0 0 0
R c 0 1 0
W c 1 0 0
R c 0 0 0

/* timerTop.f */
+incdir+logic
logic/timerPkg.sv
logic/timerRegs.sv
logic/timerCore.sv
logic/timerTop.sv
dv/timerTb_assert.sv
dv/timerTb.sv

/* Bender.yml */
package:
  name: timer

sources:
  - include_dirs:
      - logic
    files:
      - logic/timerPkg.sv
      - logic/timerRegs.sv
      - logic/timerCore.sv
      - logic/timerTop.sv
      - target: test
        files:
          - dv/timerTb_assert.sv
          - dv/timerTb.sv
